/* csr_pkg.sv */
package csr_pkg;

    // ------------------------------------------------------------------
    // sizes
    // ------------------------------------------------------------------
    localparam int XLEN     = 32;
    localparam int IDX_W    = 12;
    localparam int IDX_LO_W = 8;    // index bits seen by the register blocks.
    localparam int IMM_W    = 5;
    localparam int CNT_W    = 64;
    localparam int CREDITS  = 2;
    localparam int CREDIT_W = 2;    // holds 0 to CREDITS.

    // block select bit positions
    localparam int SEL_CNT  = 0;
    localparam int SEL_MACH = 1;

    // ------------------------------------------------------------------
    // CSR indexes
    // ------------------------------------------------------------------
    localparam logic [IDX_W-1:0] IDX_CYCLE    = 12'hC00;
    localparam logic [IDX_W-1:0] IDX_INSTRET  = 12'hC02;
    localparam logic [IDX_W-1:0] IDX_CYCLEH   = 12'hC80;
    localparam logic [IDX_W-1:0] IDX_INSTRETH = 12'hC82;
    localparam logic [IDX_W-1:0] IDX_MSTATUS  = 12'h300;
    localparam logic [IDX_W-1:0] IDX_MTVEC    = 12'h305;
    localparam logic [IDX_W-1:0] IDX_MSCRATCH = 12'h340;
    localparam logic [IDX_W-1:0] IDX_MEPC     = 12'h341;
    localparam logic [IDX_W-1:0] IDX_MCAUSE   = 12'h342;

    localparam logic [XLEN-1:0] MSTATUS_MASK     = 32'h0000_0088;  // MPIE and MIE.
    localparam logic [XLEN-1:0] CAUSE_BREAKPOINT = 32'd3;

    // ------------------------------------------------------------------
    // types
    // ------------------------------------------------------------------
    typedef enum logic [1:0]
    {
        OP_RW     = 2'd0,
        OP_RS     = 2'd1,
        OP_RC     = 2'd2,
        OP_EBREAK = 2'd3
    } csr_op_e;

    typedef enum logic
    {
        ST_IDLE = 1'b0,
        ST_EXEC = 1'b1
    } csr_state_e;

endpackage

/* csr_op_if.sv */
`timescale 1ns/1ps

interface csr_op_if;

    logic                           valid;
    csr_pkg::csr_op_e               op;
    logic [csr_pkg::IDX_LO_W-1:0]   idx;
    logic [csr_pkg::XLEN-1:0]       wdata;
    logic [1:0]                     sel;    // one-hot block select.
    logic [csr_pkg::XLEN-1:0]       pc;

    modport ctrl
    (
        output valid, op, idx, wdata, sel, pc
    );

    modport regs
    (
        input valid, op, idx, wdata, sel, pc
    );

endinterface

/* csr_ctrl.sv */
`timescale 1ns/1ps

module csr_ctrl
(
    input  logic                        i_clk,
    input  logic                        i_arst_n,
    input  logic                        i_req_valid,
    input  csr_pkg::csr_op_e            i_req_op,
    input  logic [csr_pkg::IDX_W-1:0]   i_req_idx,
    input  logic                        i_req_imm_sel,
    input  logic [csr_pkg::IMM_W-1:0]   i_req_imm,
    input  logic [csr_pkg::XLEN-1:0]    i_req_rdata,
    input  logic [csr_pkg::XLEN-1:0]    i_req_pc,
    input  logic [csr_pkg::XLEN-1:0]    i_cnt_rdata,
    input  logic                        i_cnt_hit,
    input  logic [csr_pkg::XLEN-1:0]    i_mach_rdata,
    input  logic                        i_mach_hit,
    output logic                        o_rsp_valid,
    output logic [csr_pkg::XLEN-1:0]    o_rsp_data,
    output logic                        o_rsp_illegal,
    output logic                        o_credit,
    output logic                        o_trap_valid,
    csr_op_if.ctrl                      op_if
);

    csr_pkg::csr_state_e            state;
    csr_pkg::csr_op_e               ex_op;
    logic [csr_pkg::IDX_W-1:0]      ex_idx;
    logic [csr_pkg::XLEN-1:0]       ex_wdata;
    logic [csr_pkg::XLEN-1:0]       ex_pc;
    logic [csr_pkg::CREDIT_W-1:0]   outstanding;
    logic [1:0]                     idx_cat;
    logic [1:0]                     sel;
    logic [csr_pkg::XLEN-1:0]       rd_data;
    logic                           rd_legal;
    logic                           exec;

    // ------------------------------------------------------------------
    // request staging
    // ------------------------------------------------------------------
    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            state <= csr_pkg::ST_IDLE;
        else
            state <= i_req_valid ? csr_pkg::ST_EXEC : csr_pkg::ST_IDLE;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_req_valid)
        begin
            ex_op    <= i_req_op;
            ex_idx   <= i_req_idx;
            ex_wdata <= i_req_imm_sel ?
                        {{(csr_pkg::XLEN-csr_pkg::IMM_W){1'b0}}, i_req_imm} : i_req_rdata;
            ex_pc    <= i_req_pc;
        end
    end

    assign exec    = (state == csr_pkg::ST_EXEC);
    assign idx_cat = ex_idx[9:8];

    // bits 11:10 must also match, so that aliases such as 0x000 or 0xB00 miss.
    always_comb
    begin
        sel = 2'b00;
        if (ex_op == csr_pkg::OP_EBREAK)
            sel[csr_pkg::SEL_MACH] = 1'b1;
        else if (idx_cat == 2'b00 && ex_idx[11:10] == csr_pkg::IDX_CYCLE[11:10])
            sel[csr_pkg::SEL_CNT] = 1'b1;
        else if (idx_cat == 2'b11 && ex_idx[11:10] == csr_pkg::IDX_MSTATUS[11:10])
            sel[csr_pkg::SEL_MACH] = 1'b1;
    end

    assign op_if.valid = exec;
    assign op_if.op    = ex_op;
    assign op_if.idx   = ex_idx[csr_pkg::IDX_LO_W-1:0];
    assign op_if.wdata = ex_wdata;
    assign op_if.sel   = sel;
    assign op_if.pc    = ex_pc;

    // ------------------------------------------------------------------
    // read multiplexing and response
    // ------------------------------------------------------------------
    always_comb
    begin
        rd_data  = '0;
        rd_legal = 1'b0;
        if (ex_op == csr_pkg::OP_EBREAK)
            rd_legal = 1'b1;    // a breakpoint answers with zero data.
        else if (sel[csr_pkg::SEL_CNT])
        begin
            rd_data  = i_cnt_rdata;
            rd_legal = i_cnt_hit;
        end
        else if (sel[csr_pkg::SEL_MACH])
        begin
            rd_data  = i_mach_rdata;
            rd_legal = i_mach_hit;
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_rsp_valid   <= 1'b0;
            o_rsp_illegal <= 1'b0;
            o_credit      <= 1'b0;
            o_trap_valid  <= 1'b0;
        end
        else
        begin
            o_rsp_valid   <= exec;
            o_rsp_illegal <= exec && !rd_legal;
            o_credit      <= exec;
            o_trap_valid  <= exec && (ex_op == csr_pkg::OP_EBREAK);
        end
    end

    always_ff @(posedge i_clk)
    begin
        o_rsp_data <= rd_legal ? rd_data : '0;
    end

    // count of requests whose credit has not come back yet.
    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            outstanding <= '0;
        else
        begin
            case ({i_req_valid, o_credit})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: ;
            endcase
        end
    end

    a_credit_limit : assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_req_valid |-> (outstanding != csr_pkg::CREDIT_W'(csr_pkg::CREDITS)));

    a_hit_selected : assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (!i_cnt_hit || (exec && sel[csr_pkg::SEL_CNT])) &&
        (!i_mach_hit || (exec && sel[csr_pkg::SEL_MACH])));

    a_exec_counted : assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (state == csr_pkg::ST_EXEC) |-> (outstanding != '0));

endmodule

/* csr_counters.sv */
`timescale 1ns/1ps

module csr_counters
(
    input  logic                        i_clk,
    input  logic                        i_arst_n,
    input  logic                        i_instr_retired,
    csr_op_if.regs                      op_if,
    output logic [csr_pkg::XLEN-1:0]    o_rdata,
    output logic                        o_hit
);

    logic [csr_pkg::CNT_W-1:0]  cycle_q;
    logic [csr_pkg::CNT_W-1:0]  instret_q;
    logic [csr_pkg::XLEN-1:0]   rd;
    logic                       idx_known;
    logic                       write_try;

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            cycle_q   <= '0;
            instret_q <= '0;
        end
        else
        begin
            cycle_q <= cycle_q + 1'b1;
            if (i_instr_retired)
                instret_q <= instret_q + 1'b1;
        end
    end

    always_comb
    begin
        idx_known = 1'b1;
        case (op_if.idx)
            csr_pkg::IDX_CYCLE[7:0]:    rd = cycle_q[31:0];
            csr_pkg::IDX_INSTRET[7:0]:  rd = instret_q[31:0];
            csr_pkg::IDX_CYCLEH[7:0]:   rd = cycle_q[63:32];
            csr_pkg::IDX_INSTRETH[7:0]: rd = instret_q[63:32];
            default:
            begin
                rd        = '0;
                idx_known = 1'b0;
            end
        endcase
    end

    // a set or clear with a zero operand is a plain read.
    assign write_try = (op_if.op == csr_pkg::OP_RW) ||
                       ((op_if.op != csr_pkg::OP_EBREAK) && (op_if.wdata != '0));

    assign o_hit   = op_if.valid && op_if.sel[csr_pkg::SEL_CNT] && idx_known && !write_try;
    assign o_rdata = o_hit ? rd : '0;

endmodule

/* csr_machine.sv */
`timescale 1ns/1ps

module csr_machine
(
    input  logic                        i_clk,
    input  logic                        i_arst_n,
    csr_op_if.regs                      op_if,
    output logic [csr_pkg::XLEN-1:0]    o_rdata,
    output logic                        o_hit,
    output logic [csr_pkg::XLEN-1:0]    o_trap_pc
);

    logic [csr_pkg::XLEN-1:0]   mstatus_q;
    logic [csr_pkg::XLEN-1:0]   mtvec_q;
    logic [csr_pkg::XLEN-1:0]   mscratch_q;
    logic [csr_pkg::XLEN-1:0]   mepc_q;
    logic [csr_pkg::XLEN-1:0]   mcause_q;
    logic [csr_pkg::XLEN-1:0]   cur;
    logic [csr_pkg::XLEN-1:0]   upd;
    logic                       idx_known;
    logic                       selected;
    logic                       trap;

    // ------------------------------------------------------------------
    // read port
    // ------------------------------------------------------------------
    always_comb
    begin
        idx_known = 1'b1;
        case (op_if.idx)
            csr_pkg::IDX_MSTATUS[7:0]:  cur = mstatus_q;
            csr_pkg::IDX_MTVEC[7:0]:    cur = mtvec_q;
            csr_pkg::IDX_MSCRATCH[7:0]: cur = mscratch_q;
            csr_pkg::IDX_MEPC[7:0]:     cur = mepc_q;
            csr_pkg::IDX_MCAUSE[7:0]:   cur = mcause_q;
            default:
            begin
                cur       = '0;
                idx_known = 1'b0;
            end
        endcase
    end

    assign selected = op_if.valid && op_if.sel[csr_pkg::SEL_MACH];
    assign trap     = selected && (op_if.op == csr_pkg::OP_EBREAK);
    assign o_hit    = selected && idx_known;
    assign o_rdata  = o_hit ? cur : '0;

    // ------------------------------------------------------------------
    // update
    // ------------------------------------------------------------------
    always_comb
    begin
        case (op_if.op)
            csr_pkg::OP_RW: upd = op_if.wdata;
            csr_pkg::OP_RS: upd = cur | op_if.wdata;
            csr_pkg::OP_RC: upd = cur & ~op_if.wdata;
            default:        upd = cur;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            mstatus_q  <= '0;
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
        end
        else if (trap)
        begin
            mepc_q   <= {op_if.pc[csr_pkg::XLEN-1:2], 2'b00};
            mcause_q <= csr_pkg::CAUSE_BREAKPOINT;
        end
        else if (o_hit)
        begin
            case (op_if.idx)
                csr_pkg::IDX_MSTATUS[7:0]:  mstatus_q  <= upd & csr_pkg::MSTATUS_MASK;
                csr_pkg::IDX_MTVEC[7:0]:    mtvec_q    <= upd;
                csr_pkg::IDX_MSCRATCH[7:0]: mscratch_q <= upd;
                csr_pkg::IDX_MEPC[7:0]:     mepc_q     <= {upd[csr_pkg::XLEN-1:2], 2'b00};
                csr_pkg::IDX_MCAUSE[7:0]:   mcause_q   <= upd;
                default: ;
            endcase
        end
    end

    assign o_trap_pc = {mtvec_q[csr_pkg::XLEN-1:2], 2'b00};   // direct mode only.

endmodule

/* csr_unit.sv */
`timescale 1ns/1ps

module csr_unit
(
    input  logic                        i_clk,
    input  logic                        i_arst_n,
    input  logic                        i_req_valid,
    input  csr_pkg::csr_op_e            i_req_op,
    input  logic [csr_pkg::IDX_W-1:0]   i_req_idx,
    input  logic                        i_req_imm_sel,
    input  logic [csr_pkg::IMM_W-1:0]   i_req_imm,
    input  logic [csr_pkg::XLEN-1:0]    i_req_rdata,
    input  logic [csr_pkg::XLEN-1:0]    i_req_pc,
    input  logic                        i_instr_retired,
    output logic                        o_rsp_valid,
    output logic [csr_pkg::XLEN-1:0]    o_rsp_data,
    output logic                        o_rsp_illegal,
    output logic                        o_credit,
    output logic                        o_trap_valid,
    output logic [csr_pkg::XLEN-1:0]    o_trap_pc
);

    logic [csr_pkg::XLEN-1:0]   cnt_rdata;
    logic                       cnt_hit;
    logic [csr_pkg::XLEN-1:0]   mach_rdata;
    logic                       mach_hit;

    csr_op_if u_op_if ();

    csr_ctrl u_ctrl
    (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_req_valid    (i_req_valid),
        .i_req_op       (i_req_op),
        .i_req_idx      (i_req_idx),
        .i_req_imm_sel  (i_req_imm_sel),
        .i_req_imm      (i_req_imm),
        .i_req_rdata    (i_req_rdata),
        .i_req_pc       (i_req_pc),
        .i_cnt_rdata    (cnt_rdata),
        .i_cnt_hit      (cnt_hit),
        .i_mach_rdata   (mach_rdata),
        .i_mach_hit     (mach_hit),
        .o_rsp_valid    (o_rsp_valid),
        .o_rsp_data     (o_rsp_data),
        .o_rsp_illegal  (o_rsp_illegal),
        .o_credit       (o_credit),
        .o_trap_valid   (o_trap_valid),
        .op_if          (u_op_if.ctrl)
    );

    csr_counters u_counters
    (
        .i_clk              (i_clk),
        .i_arst_n           (i_arst_n),
        .i_instr_retired    (i_instr_retired),
        .op_if              (u_op_if.regs),
        .o_rdata            (cnt_rdata),
        .o_hit              (cnt_hit)
    );

    csr_machine u_machine
    (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .op_if      (u_op_if.regs),
        .o_rdata    (mach_rdata),
        .o_hit      (mach_hit),
        .o_trap_pc  (o_trap_pc)
    );

endmodule

/* tb_csr_unit.sv */
`timescale 1ns/1ps

module tb_csr_unit;

    localparam int          NUM_REQ    = 2000;
    localparam int          MAX_CYCLES = NUM_REQ * 2 + 50;  // two credits allow 2 requests per 3 cycles.
    localparam logic [31:0] SEED       = 32'h4b15d609;
    localparam logic [31:0] TAPS       = 32'h8020_0003;

    typedef struct packed
    {
        logic [31:0] data;
        logic        illegal;
        logic        trap;
        logic [31:0] trap_pc;
        logic [31:0] due;       // edge count at which the response is checked.
    } rsp_t;

    logic               i_clk;
    logic               i_arst_n;
    logic               i_req_valid;
    csr_pkg::csr_op_e   i_req_op;
    logic [11:0]        i_req_idx;
    logic               i_req_imm_sel;
    logic [4:0]         i_req_imm;
    logic [31:0]        i_req_rdata;
    logic [31:0]        i_req_pc;
    logic               i_instr_retired;
    logic               o_rsp_valid;
    logic [31:0]        o_rsp_data;
    logic               o_rsp_illegal;
    logic               o_credit;
    logic               o_trap_valid;
    logic [31:0]        o_trap_pc;

    logic [31:0]        lfsr;
    logic [63:0]        m_cycle;
    logic [63:0]        m_instret;
    logic [31:0]        m_mstatus;
    logic [31:0]        m_mtvec;
    logic [31:0]        m_mscratch;
    logic [31:0]        m_mepc;
    logic [31:0]        m_mcause;
    rsp_t               expected[$];
    int                 credits;
    int                 issued;
    int                 edge_count;

    csr_unit dut_i
    (
        .i_clk              (i_clk),
        .i_arst_n           (i_arst_n),
        .i_req_valid        (i_req_valid),
        .i_req_op           (i_req_op),
        .i_req_idx          (i_req_idx),
        .i_req_imm_sel      (i_req_imm_sel),
        .i_req_imm          (i_req_imm),
        .i_req_rdata        (i_req_rdata),
        .i_req_pc           (i_req_pc),
        .i_instr_retired    (i_instr_retired),
        .o_rsp_valid        (o_rsp_valid),
        .o_rsp_data         (o_rsp_data),
        .o_rsp_illegal      (o_rsp_illegal),
        .o_credit           (o_credit),
        .o_trap_valid       (o_trap_valid),
        .o_trap_pc          (o_trap_pc)
    );

    always #5 i_clk = ~i_clk;

    // ----------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------
    task automatic report_error(input string msg);
        $display("ERR %0t: %s", $time, msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++)
        begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ TAPS) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic logic [11:0] index_of(input logic [3:0] pick);
        case (pick)
            4'd0:    return csr_pkg::IDX_MSTATUS;
            4'd1:    return csr_pkg::IDX_MTVEC;
            4'd2:    return csr_pkg::IDX_MSCRATCH;
            4'd3:    return csr_pkg::IDX_MEPC;
            4'd4:    return csr_pkg::IDX_MCAUSE;
            4'd5:    return csr_pkg::IDX_CYCLE;
            4'd6:    return csr_pkg::IDX_CYCLEH;
            4'd7:    return csr_pkg::IDX_INSTRET;
            4'd8:    return csr_pkg::IDX_INSTRETH;
            4'd9:    return 12'h100;    // sstatus.
            4'd10:   return 12'h141;    // sepc.
            4'd11:   return 12'h600;    // hstatus.
            4'd12:   return 12'h643;    // htval.
            4'd13:   return 12'hC01;    // time is not implemented.
            4'd14:   return 12'h344;    // neither is mip.
            default: return 12'(rand_bits(12));
        endcase
    endfunction

    // applies one request to the model state and returns its response.
    task automatic model_request(input csr_pkg::csr_op_e op, input logic [11:0] idx,
                                 input logic [31:0] wdata, input logic [31:0] pc,
                                 output rsp_t rsp);
        logic [31:0] cur;
        logic [31:0] nxt;
        logic        hit;
        logic        cnt;
        rsp = '0;
        cur = '0;
        hit = 1'b1;
        cnt = 1'b0;
        if (op == csr_pkg::OP_EBREAK)
        begin
            rsp.trap    = 1'b1;
            rsp.trap_pc = m_mtvec & ~32'h3;
            m_mepc      = pc & ~32'h3;
            m_mcause    = csr_pkg::CAUSE_BREAKPOINT;
        end
        else
        begin
            case (idx)
                csr_pkg::IDX_CYCLE:    begin cur = m_cycle[31:0];    cnt = 1'b1; end
                csr_pkg::IDX_CYCLEH:   begin cur = m_cycle[63:32];   cnt = 1'b1; end
                csr_pkg::IDX_INSTRET:  begin cur = m_instret[31:0];  cnt = 1'b1; end
                csr_pkg::IDX_INSTRETH: begin cur = m_instret[63:32]; cnt = 1'b1; end
                csr_pkg::IDX_MSTATUS:  cur = m_mstatus;
                csr_pkg::IDX_MTVEC:    cur = m_mtvec;
                csr_pkg::IDX_MSCRATCH: cur = m_mscratch;
                csr_pkg::IDX_MEPC:     cur = m_mepc;
                csr_pkg::IDX_MCAUSE:   cur = m_mcause;
                default:               hit = 1'b0;
            endcase
            if (cnt && (op == csr_pkg::OP_RW || wdata != 32'd0))
                hit = 1'b0;     // counters are read-only.
            case (op)
                csr_pkg::OP_RW: nxt = wdata;
                csr_pkg::OP_RS: nxt = cur | wdata;
                default:        nxt = cur & ~wdata;
            endcase
            if (hit && !cnt)
            begin
                case (idx)
                    csr_pkg::IDX_MSTATUS:  m_mstatus  = nxt & csr_pkg::MSTATUS_MASK;
                    csr_pkg::IDX_MTVEC:    m_mtvec    = nxt;
                    csr_pkg::IDX_MSCRATCH: m_mscratch = nxt;
                    csr_pkg::IDX_MEPC:     m_mepc     = nxt & ~32'h3;
                    default:               m_mcause   = nxt;
                endcase
            end
            rsp.data    = hit ? cur : 32'd0;
            rsp.illegal = !hit;
        end
    endtask

    task automatic issue_request();
        logic [11:0]      idx;
        csr_pkg::csr_op_e op;
        idx = index_of(4'(rand_bits(4)));
        if (4'(rand_bits(4)) == 4'd0)
            op = csr_pkg::OP_EBREAK;
        else
            op = csr_pkg::csr_op_e'(2'(rand_bits(2)));
        i_req_valid <= 1'b1;
        i_req_idx   <= idx;
        if (op != csr_pkg::OP_EBREAK && idx[11:8] == 4'hC && rand_bits(1) == 32'd1)
        begin
            i_req_op      <= csr_pkg::OP_RS;    // plain counter read.
            i_req_imm_sel <= 1'b1;
            i_req_imm     <= 5'd0;
        end
        else
        begin
            i_req_op      <= op;
            i_req_imm_sel <= 1'(rand_bits(1));
            i_req_imm     <= 5'(rand_bits(5));
        end
        i_req_rdata <= rand_bits(32);
        i_req_pc    <= rand_bits(32);
    endtask

    // ----------------------------------------------------------------------
    // stimulus, model and checks
    // ----------------------------------------------------------------------
    always @(posedge i_clk)
    begin
        rsp_t        rsp;
        logic [31:0] wdata;
        edge_count = edge_count + 1;
        if (edge_count > MAX_CYCLES)
        begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
        if (i_arst_n)
        begin
            m_cycle = m_cycle + 64'd1;
            if (i_instr_retired)
                m_instret = m_instret + 64'd1;
            if (i_req_valid)
            begin
                wdata = i_req_imm_sel ? {27'd0, i_req_imm} : i_req_rdata;
                model_request(i_req_op, i_req_idx, wdata, i_req_pc, rsp);
                rsp.due = 32'(edge_count + 1);
                expected.push_back(rsp);
            end
            i_instr_retired <= 1'(rand_bits(1));
            if (credits > 0 && issued < NUM_REQ)
            begin
                issue_request();
                credits = credits - 1;
                issued  = issued + 1;
            end
            else
                i_req_valid <= 1'b0;
        end
    end

    always @(negedge i_clk)
    begin
        rsp_t exp;
        assert (o_credit == o_rsp_valid)
            else report_error("credit pulse does not match response valid");
        if (o_credit)
            credits = credits + 1;
        if (o_rsp_valid)
        begin
            assert (expected.size() > 0)
                else report_error("response without a pending request");
            exp = expected.pop_front();
            assert (exp.due == 32'(edge_count))
                else report_error("response latency is not two edges");
            assert (o_rsp_data == exp.data)
                else report_error($sformatf("rsp data %h, expected %h", o_rsp_data, exp.data));
            assert (o_rsp_illegal == exp.illegal)
                else report_error($sformatf("illegal flag %b, expected %b",
                                            o_rsp_illegal, exp.illegal));
            assert (o_trap_valid == exp.trap)
                else report_error($sformatf("trap valid %b, expected %b", o_trap_valid, exp.trap));
            if (exp.trap)
            begin
                assert (o_trap_pc == exp.trap_pc)
                    else report_error($sformatf("trap pc %h, expected %h", o_trap_pc, exp.trap_pc));
            end
        end
        else
        begin
            assert (!o_trap_valid)
                else report_error("trap valid without a response");
        end
    end

    initial
    begin
        i_clk           = 1'b0;
        i_arst_n        = 1'b0;
        i_req_valid     = 1'b0;
        i_req_op        = csr_pkg::OP_RW;
        i_req_idx       = '0;
        i_req_imm_sel   = 1'b0;
        i_req_imm       = '0;
        i_req_rdata     = '0;
        i_req_pc        = '0;
        i_instr_retired = 1'b0;
        lfsr            = SEED;
        m_cycle         = '0;
        m_instret       = '0;
        m_mstatus       = '0;
        m_mtvec         = '0;
        m_mscratch      = '0;
        m_mepc          = '0;
        m_mcause        = '0;
        credits         = csr_pkg::CREDITS;
        issued          = 0;
        edge_count      = 0;
        repeat (5) @(posedge i_clk);
        i_arst_n <= 1'b1;
        @(posedge i_clk);
        while (issued < NUM_REQ || expected.size() != 0 || credits != csr_pkg::CREDITS)
            @(posedge i_clk);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* src.f */
csr_pkg.sv
csr_op_if.sv
csr_ctrl.sv
csr_counters.sv
csr_machine.sv
csr_unit.sv
tb_csr_unit.sv

/* run.sh */
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_csr_unit \
    --Mdir obj_dir -o tb_csr_unit \
    -f src.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build ended with status $status"
    exit "$status"
fi

./obj_dir/tb_csr_unit
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation run ended with status $status"
    exit "$status"
fi

exit 0
